// ==== verilog/video_out_defines.svh ====
`ifndef VIDEO_OUT_DEFINES_SVH
`define VIDEO_OUT_DEFINES_SVH

// ========================================
// video format
// ========================================
`define VO_COLOR_W 8  // bits per colour channel

// ========================================
// board controls
// ========================================
`define VO_NUM_KEYS 2    // push keys on the panel
`define VO_STRETCH_W 24  // ~0.6 s at 27 MHz

// ========================================
// osd palette, packed as {r, g, b}
// ========================================
`define VO_OSD_COL0 24'h00_00_00  // black
`define VO_OSD_COL1 24'h00_00_ff  // blue
`define VO_OSD_COL2 24'hff_ff_00  // yellow
`define VO_OSD_COL3 24'hff_ff_ff  // white

`endif

// ==== verilog/video_out_pkg.sv ====
`default_nettype none

`include "video_out_defines.svh"

package video_out_pkg;

    // ========================================
    // video bus
    // ========================================
    // syncs active low, de active high
    typedef struct packed {
        logic [`VO_COLOR_W-1:0] r;
        logic [`VO_COLOR_W-1:0] g;
        logic [`VO_COLOR_W-1:0] b;
        logic                   hsync;
        logic                   vsync;
        logic                   de;
    } pixel_t;

    // osd generator output, one per pixel
    typedef struct packed {
        logic       enable;
        logic [1:0] color;  // palette index
    } osd_t;

    // push keys, pressed = 0
    typedef logic [`VO_NUM_KEYS-1:0] keys_t;

    // blanked pixel with both syncs released
    localparam pixel_t PIXEL_IDLE = '{r: '0, g: '0, b: '0, hsync: 1'b1, vsync: 1'b1, de: 1'b0};

endpackage

`default_nettype wire

// ==== verilog/cdc_sync2.sv ====
`default_nettype none

// two-flop synchronizer for any packed payload
module cdc_sync2 #(
    parameter type T         = logic,
    parameter T    RESET_VAL = '0
) (
    input  wire  clk27,
    input  wire  sys_reset_n,
    input  T     async_i,
    output T     sync_o
);

    T meta_q;  // first stage, may go metastable
    T sync_q;

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            meta_q <= RESET_VAL;
            sync_q <= RESET_VAL;
        end else begin
            meta_q <= async_i;
            sync_q <= meta_q;
        end
    end

    assign sync_o = sync_q;

endmodule

`default_nettype wire

// ==== verilog/panel_input.sv ====
`default_nettype none

// keys and resync strobe into the clk27 domain
module panel_input (
    input  wire                   clk27,
    input  wire                   sys_reset_n,
    input  video_out_pkg::keys_t  keys_i,
    input  wire                   resync_strobe_i,
    output video_out_pkg::keys_t  keys_o,
    output logic                  resync_pulse_o
);

    logic resync_sync;
    logic resync_prev;

    // ========================================
    // synchronizers
    // ========================================
    // keys idle high, so reset to released
    cdc_sync2 #(
        .T         (video_out_pkg::keys_t),
        .RESET_VAL (video_out_pkg::keys_t'('1))
    ) u_key_sync (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .async_i     (keys_i),
        .sync_o      (keys_o)
    );

    cdc_sync2 #(
        .T         (logic),
        .RESET_VAL (1'b0)
    ) u_resync_sync (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .async_i     (resync_strobe_i),
        .sync_o      (resync_sync)
    );

    // ========================================
    // rising edge of the strobe
    // ========================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            resync_prev <= 1'b0;
        end else begin
            resync_prev <= resync_sync;
        end
    end

    // one clk27 cycle per strobe rise
    assign resync_pulse_o = resync_sync & ~resync_prev;

endmodule

`default_nettype wire

// ==== verilog/osd_overlay.sv ====
`default_nettype none

`include "video_out_defines.svh"

// osd mix, first output register stage
module osd_overlay (
    input  wire                    clk27,
    input  wire                    sys_reset_n,
    input  video_out_pkg::pixel_t  pix_i,
    input  video_out_pkg::osd_t    osd_i,
    output video_out_pkg::pixel_t  pix_o
);

    video_out_pkg::pixel_t mix_d;
    video_out_pkg::pixel_t mix_q;

    // four entry palette lookup, returns {r, g, b}
    function automatic logic [3*`VO_COLOR_W-1:0] palette_rgb(input logic [1:0] idx);
        logic [3*`VO_COLOR_W-1:0] rgb;
        case (idx)
            2'd0:    rgb = `VO_OSD_COL0;
            2'd1:    rgb = `VO_OSD_COL1;
            2'd2:    rgb = `VO_OSD_COL2;
            default: rgb = `VO_OSD_COL3;
        endcase
        return rgb;
    endfunction

    // ========================================
    // overlay select
    // ========================================
    always_comb begin
        mix_d = pix_i;  // syncs and de pass as is
        if (osd_i.enable) begin
            {mix_d.r, mix_d.g, mix_d.b} = palette_rgb(osd_i.color);
        end
    end

    // ========================================
    // stage 1 register
    // ========================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            mix_q <= video_out_pkg::PIXEL_IDLE;
        end else begin
            mix_q <= mix_d;
        end
    end

    assign pix_o = mix_q;

endmodule

`default_nettype wire

// ==== verilog/resync_led_stretch.sv ====
`default_nettype none

`include "video_out_defines.svh"

// makes the one-cycle resync pulse visible on an LED
module resync_led_stretch #(
    parameter int STRETCH_W = `VO_STRETCH_W
) (
    input  wire   clk27,
    input  wire   sys_reset_n,
    input  wire   resync_pulse_i,
    output logic  led_o
);

    logic [STRETCH_W-1:0] led_cnt;

    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            led_cnt <= '0;
        end else if (resync_pulse_i) begin
            led_cnt <= '1;  // retrigger restarts the full period
        end else if (led_cnt != '0) begin
            led_cnt <= led_cnt - 1'b1;
        end
    end

    // lit until the counter runs out
    assign led_o = (led_cnt != '0);

endmodule

`default_nettype wire

// ==== verilog/hdmi_tx_port.sv ====
`default_nettype none

// last register stage before the hdmi transmitter
module hdmi_tx_port (
    input  wire                    clk27,
    input  wire                    sys_reset_n,
    input  video_out_pkg::pixel_t  pix_i,
    output video_out_pkg::pixel_t  tx_o,
    output logic                   frame_start_o
);

    video_out_pkg::pixel_t tx_q;
    logic                  vsync_prev;  // tx vsync one cycle back

    // ========================================
    // stage 2 register
    // ========================================
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            tx_q <= video_out_pkg::PIXEL_IDLE;
        end else begin
            tx_q <= pix_i;
        end
    end

    assign tx_o = tx_q;

    // ========================================
    // frame start
    // ========================================
    // reset to released, matching the idle pixel
    always_ff @(posedge clk27 or negedge sys_reset_n) begin
        if (!sys_reset_n) begin
            vsync_prev <= 1'b1;
        end else begin
            vsync_prev <= tx_q.vsync;
        end
    end

    // vsync falling edge, only counted with hsync asserted
    assign frame_start_o = vsync_prev & ~tx_q.vsync & ~tx_q.hsync;

endmodule

`default_nettype wire

// ==== verilog/video_out_top.sv ====
`default_nettype none

`include "video_out_defines.svh"

// video output and panel glue, all on clk27
module video_out_top #(
    parameter int STRETCH_W = `VO_STRETCH_W
) (
    input  wire                    clk27,
    input  wire                    sys_reset_n,

    // from the scan converter, already in clk27
    input  video_out_pkg::pixel_t  pix_i,
    input  video_out_pkg::osd_t    osd_i,

    // board inputs, asynchronous
    input  video_out_pkg::keys_t   keys_i,
    input  wire                    resync_strobe_i,

    // hdmi transmitter
    output video_out_pkg::pixel_t  tx_o,
    output logic                   frame_start_o,

    // panel side
    output video_out_pkg::keys_t   keys_o,
    output logic                   resync_led_o
);

    logic                  resync_pulse;
    video_out_pkg::pixel_t stage1_pix;  // after osd mix

    // ========================================
    // panel controls
    // ========================================
    panel_input u_panel_input (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .keys_i          (keys_i),
        .resync_strobe_i (resync_strobe_i),
        .keys_o          (keys_o),
        .resync_pulse_o  (resync_pulse)
    );

    resync_led_stretch #(
        .STRETCH_W (STRETCH_W)
    ) u_resync_led (
        .clk27          (clk27),
        .sys_reset_n    (sys_reset_n),
        .resync_pulse_i (resync_pulse),
        .led_o          (resync_led_o)
    );

    // ========================================
    // pixel path, two register stages
    // ========================================
    osd_overlay u_osd_overlay (
        .clk27       (clk27),
        .sys_reset_n (sys_reset_n),
        .pix_i       (pix_i),
        .osd_i       (osd_i),
        .pix_o       (stage1_pix)
    );

    hdmi_tx_port u_hdmi_tx_port (
        .clk27         (clk27),
        .sys_reset_n   (sys_reset_n),
        .pix_i         (stage1_pix),
        .tx_o          (tx_o),
        .frame_start_o (frame_start_o)
    );

endmodule

`default_nettype wire

// ==== verification/video_out_properties.sv ====
`default_nettype none

// checks on the transmitter port, bound into hdmi_tx_port
module video_out_properties (
    input wire                         clk27,
    input wire                         sys_reset_n,
    input wire video_out_pkg::pixel_t  tx_o,
    input wire                         frame_start_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // ========================================
    // reset
    // ========================================
    // first sample out of reset still shows the idle pixel
    de_low_after_reset: assert property (
        @(posedge clk27) $rose(sys_reset_n) |-> !tx_o.de
    ) else $error("tx_o.de is high in the first cycle after reset");

    // ========================================
    // frame start
    // ========================================
    start_with_vsync: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        frame_start_o |-> !tx_o.vsync
    ) else $error("frame_start_o is high while tx_o.vsync is released");

    start_single_cycle: assert property (
        @(posedge clk27) disable iff (!sys_reset_n)
        frame_start_o |=> !frame_start_o
    ) else $error("frame_start_o is high in two consecutive cycles");

endmodule

bind hdmi_tx_port video_out_properties u_properties (
    .clk27         (clk27),
    .sys_reset_n   (sys_reset_n),
    .tx_o          (tx_o),
    .frame_start_o (frame_start_o)
);

`default_nettype wire

// ==== verification/video_out_tb.sv ====
`default_nettype none

`include "video_out_defines.svh"

module video_out_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          STRETCH_W      = 4;
    localparam int          LED_CYCLES     = (1 << STRETCH_W) - 1;
    localparam int          STROBE_TIMEOUT = 100;  // cycles per strobe run
    localparam logic [31:0] SEED           = 32'hcb74cee1;

    logic                  clk27;
    logic                  sys_reset_n;
    video_out_pkg::pixel_t pix_i;
    video_out_pkg::osd_t   osd_i;
    video_out_pkg::keys_t  keys_i;
    logic                  resync_strobe_i;
    video_out_pkg::pixel_t tx_o;
    logic                  frame_start_o;
    video_out_pkg::keys_t  keys_o;
    logic                  resync_led_o;

    int check_count   = 0;
    int error_count   = 0;
    int timeout_count = 0;

    // model state of the compare process
    video_out_pkg::pixel_t exp_pix_q[$];
    video_out_pkg::keys_t  exp_keys_q[$];
    video_out_pkg::pixel_t last_tx_exp;
    logic [3:0]            strobe_hist;  // bit 0 is one cycle back
    int                    led_left;

    video_out_top #(
        .STRETCH_W (STRETCH_W)
    ) dut (
        .clk27           (clk27),
        .sys_reset_n     (sys_reset_n),
        .pix_i           (pix_i),
        .osd_i           (osd_i),
        .keys_i          (keys_i),
        .resync_strobe_i (resync_strobe_i),
        .tx_o            (tx_o),
        .frame_start_o   (frame_start_o),
        .keys_o          (keys_o),
        .resync_led_o    (resync_led_o)
    );

    initial begin
        clk27 = 1'b0;
        forever #2 clk27 = ~clk27;
    end

    // ========================================
    // reference model and helpers
    // ========================================
    function automatic video_out_pkg::pixel_t expected_pixel(
        input video_out_pkg::pixel_t pix,
        input video_out_pkg::osd_t   osd
    );
        logic [3*`VO_COLOR_W-1:0] palette [4];
        video_out_pkg::pixel_t    result;
        palette[0] = `VO_OSD_COL0;
        palette[1] = `VO_OSD_COL1;
        palette[2] = `VO_OSD_COL2;
        palette[3] = `VO_OSD_COL3;
        result = pix;  // syncs and de always from the input
        if (osd.enable) begin
            {result.r, result.g, result.b} = palette[osd.color];
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk27);
        #1;
    endtask

    task automatic drive_random_pixels(input int count, input logic osd_on);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            rnd = $urandom;
            {pix_i.r, pix_i.g, pix_i.b} = rnd[3*`VO_COLOR_W-1:0];
            rnd = $urandom;
            pix_i.hsync  = rnd[0];
            pix_i.vsync  = rnd[1];
            pix_i.de     = rnd[2];
            osd_i.color  = rnd[4:3];
            osd_i.enable = osd_on;
            next_cycle();
        end
    endtask

    // vsync low for two lines, falling at vs_offset within the line
    task automatic drive_sync_frame(input int vs_offset, input int exp_starts);
        int starts;
        int pos;
        starts = 0;
        osd_i = '0;
        pix_i = video_out_pkg::PIXEL_IDLE;
        repeat (3) next_cycle();  // flush random syncs
        for (int line = 0; line < 6; line++) begin
            for (int px = 0; px < 8; px++) begin
                pos = line * 8 + px;
                pix_i.hsync = (px >= 2);  // hsync low on the first two pixels
                pix_i.vsync = !(pos >= 16 + vs_offset && pos < 32 + vs_offset);
                pix_i.de    = (px >= 2);
                next_cycle();
                if (frame_start_o) begin
                    starts++;
                end
            end
        end
        repeat (3) begin
            next_cycle();
            if (frame_start_o) begin
                starts++;
            end
        end
        check_value("frame_start_o count", starts, exp_starts);
    endtask

    task automatic drive_random_keys(input int count);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            rnd = $urandom;
            keys_i = rnd[`VO_NUM_KEYS-1:0];
            next_cycle();
        end
        keys_i = '1;
    endtask

    // strobe high for two cycles, optional second rise at cycle second_at
    task automatic run_strobe(input int second_at, input int exp_rise, input int exp_fall);
        int t;
        int rise_t;
        int fall_t;
        t = 0;
        rise_t = -1;
        fall_t = -1;
        resync_strobe_i = 1'b1;
        while (fall_t < 0 && t < STROBE_TIMEOUT) begin
            next_cycle();
            t++;
            if (t == 2 || (second_at > 0 && t == second_at + 2)) begin
                resync_strobe_i = 1'b0;
            end
            if (second_at > 0 && t == second_at) begin
                resync_strobe_i = 1'b1;
            end
            if (resync_led_o && rise_t < 0) begin
                rise_t = t;
            end
            if (!resync_led_o && rise_t >= 0) begin
                fall_t = t;
            end
        end
        if (fall_t < 0) begin
            timeout_count++;
            $display("Timeout: resync LED did not finish its pulse within %0d cycles",
                     STROBE_TIMEOUT);
        end else begin
            check_value("resync_led_o rise cycle", rise_t, exp_rise);
            check_value("resync_led_o fall cycle", fall_t, exp_fall);
        end
    endtask

    // ========================================
    // compare process, samples mid cycle
    // ========================================
    always @(negedge clk27) begin : compare_outputs
        video_out_pkg::pixel_t cur_tx;
        video_out_pkg::keys_t  cur_keys;
        logic                  exp_frame;
        logic                  exp_led;
        if (!sys_reset_n) begin
            exp_pix_q.delete();
            exp_keys_q.delete();
            last_tx_exp = video_out_pkg::PIXEL_IDLE;
            strobe_hist = '0;
            led_left    = 0;
        end else begin
            cur_tx   = video_out_pkg::PIXEL_IDLE;  // pipeline still holds reset values
            cur_keys = '1;
            if (exp_pix_q.size() >= 2) begin
                cur_tx = exp_pix_q.pop_front();
            end
            if (exp_keys_q.size() >= 2) begin
                cur_keys = exp_keys_q.pop_front();
            end
            exp_frame = last_tx_exp.vsync & ~cur_tx.vsync & ~cur_tx.hsync;
            if (strobe_hist[2] && !strobe_hist[3]) begin
                led_left = LED_CYCLES;  // strobe rose three samples back
            end
            exp_led = (led_left > 0);
            if (led_left > 0) begin
                led_left--;
            end

            check_value("tx_o", 32'(tx_o), 32'(cur_tx));
            check_value("frame_start_o", 32'(frame_start_o), 32'(exp_frame));
            check_value("keys_o", 32'(keys_o), 32'(cur_keys));
            check_value("resync_led_o", 32'(resync_led_o), 32'(exp_led));

            exp_pix_q.push_back(expected_pixel(pix_i, osd_i));
            exp_keys_q.push_back(keys_i);
            last_tx_exp = cur_tx;
            strobe_hist = {strobe_hist[2:0], resync_strobe_i};
        end
    end

    // ========================================
    // stimulus
    // ========================================
    initial begin : stimulus
        void'($urandom(SEED));
        sys_reset_n     = 1'b0;
        pix_i           = video_out_pkg::PIXEL_IDLE;
        osd_i           = '0;
        keys_i          = '1;  // released
        resync_strobe_i = 1'b0;
        repeat (8) @(posedge clk27);
        #1 sys_reset_n = 1'b1;

        check_value("tx_o", 32'(tx_o), 32'(video_out_pkg::PIXEL_IDLE));
        check_value("keys_o", 32'(keys_o), 32'(video_out_pkg::keys_t'('1)));
        check_value("resync_led_o", 32'(resync_led_o), 32'(1'b0));
        check_value("frame_start_o", 32'(frame_start_o), 32'(1'b0));

        drive_random_pixels(64, 1'b0);
        drive_random_pixels(64, 1'b1);
        drive_sync_frame(0, 1);  // vsync falls inside the hsync pulse
        drive_sync_frame(4, 0);  // falls mid line
        drive_random_keys(24);
        repeat (3) next_cycle();
        run_strobe(0, 3, 3 + LED_CYCLES);
        repeat (4) next_cycle();
        run_strobe(6, 3, 3 + 6 + LED_CYCLES);  // reload extends by the gap
        repeat (4) next_cycle();

        $display("checks: %0d  errors: %0d  timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== video_out.f ====
+incdir+verilog
verilog/video_out_pkg.sv
verilog/cdc_sync2.sv
verilog/panel_input.sv
verilog/osd_overlay.sv
verilog/resync_led_stretch.sv
verilog/hdmi_tx_port.sv
verilog/video_out_top.sv
verification/video_out_properties.sv
verification/video_out_tb.sv

// ==== Makefile ====
# Verilator flow for the video output block

VERILATOR ?= verilator
FILELIST  ?= video_out.f
TB_TOP    ?= video_out_tb
RTL_TOP   ?= video_out_top
OBJ_DIR   ?= ./obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4
PASS_MSG  ?= Test OK

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard verilog/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

# design alone, then design with testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(SIM_BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -Mdir $(OBJ_DIR) \
		-f $(FILELIST) --top-module $(TB_TOP)

# status comes from the search for the pass line
sim: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
